// File: common/robPkg.sv
package robPkg;

    // slot index bits; every tag carries one more bit for the wrap direction.
    localparam int robIdxWidth = 4;

    // tag wide, so a full buffer of sixteen free slots still fits the free count.
    localparam logic [robIdxWidth:0] robSize = 16;

    localparam int dispatchWidth = 2; // lanes accepted per cycle.
    localparam int commitWidth = 2; // lanes retired or walked per cycle.
    localparam int wbPorts = 2;

    localparam int archRegWidth = 5;
    localparam int physRegWidth = 6;

    // payload layout is {we, vrd, prd}.
    localparam int entryWidth = 1 + archRegWidth + physRegWidth;

endpackage

// File: common/robIf.sv
`timescale 1ns/10ps

interface dispatchIf
    import robPkg::*;
();

    logic [dispatchWidth-1:0] en; // lanes fill from lane 0 upward.
    logic [dispatchWidth-1:0] we;
    logic [dispatchWidth-1:0][archRegWidth-1:0] vrd;
    logic [dispatchWidth-1:0][physRegWidth-1:0] prd;
    logic ready;
    logic [robIdxWidth:0] robTag; // tail tag, lane i lands at robTag + i.

    modport driver (
        output en, we, vrd, prd,
        input ready, robTag
    );

    modport sink (
        input en, we, vrd, prd,
        output ready, robTag
    );

endinterface

interface retireIf
    import robPkg::*;
();

    logic [commitWidth-1:0] commitEn;
    logic [commitWidth-1:0] commitWe;
    logic [commitWidth-1:0][archRegWidth-1:0] commitVrd;
    logic [commitWidth-1:0][physRegWidth-1:0] commitPrd;

    logic walking; // rename holds off while the buffer rolls back.
    logic [commitWidth-1:0] walkEn; // lane 0 is always the newest dropped slot.
    logic [commitWidth-1:0] walkWe;
    logic [commitWidth-1:0][archRegWidth-1:0] walkVrd;
    logic [commitWidth-1:0][physRegWidth-1:0] walkPrd;

    modport source (
        output commitEn, commitWe, commitVrd, commitPrd,
        output walking, walkEn, walkWe, walkVrd, walkPrd
    );

    modport sink (
        input commitEn, commitWe, commitVrd, commitPrd,
        input walking, walkEn, walkWe, walkVrd, walkPrd
    );

endinterface

// File: rob/robDataRam.sv
`timescale 1ns/10ps

module robDataRam
    import robPkg::*;
(
    input  logic clk,
    input  logic [dispatchWidth-1:0] we,
    input  logic [dispatchWidth-1:0][robIdxWidth-1:0] waddr,
    input  logic [dispatchWidth-1:0][entryWidth-1:0] wdata,
    input  logic [commitWidth-1:0][robIdxWidth-1:0] raddr,
    output logic [commitWidth-1:0][entryWidth-1:0] rdata
);

    logic [entryWidth-1:0] mem [robSize];

    always_ff @(posedge clk) begin
        for (int i = 0; i < dispatchWidth; i++) begin
            if (we[i]) begin
                mem[waddr[i]] <= wdata[i];
            end
        end
    end

    // reads are combinational so the buffer can register the result itself.
    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            rdata[i] = mem[raddr[i]];
        end
    end

    // dispatch lanes map to consecutive slots, so a collision means the tail logic broke.
    assert property (@(posedge clk) we[0] && we[1] |-> waddr[0] != waddr[1])
        else $error("both write ports hit slot %0d in one cycle.", waddr[0]);

endmodule

// File: rob/reorderBuffer.sv
`timescale 1ns/10ps

module reorderBuffer
    import robPkg::*;
(
    input  logic clk,
    input  logic rstN,
    dispatchIf.sink dispatch,
    input  logic [wbPorts-1:0] wbEn,
    input  logic [wbPorts-1:0][robIdxWidth-1:0] wbIdx,
    input  logic redirectEn,
    input  logic [robIdxWidth:0] redirectTag,
    retireIf.source retire
);

    logic inWalk; // the FSM state, high while dropped slots remain.
    logic [robIdxWidth:0] head;
    logic [robIdxWidth:0] tail;
    logic [robIdxWidth:0] freeCount;
    logic [robIdxWidth:0] occupied;
    logic [robIdxWidth:0] walkRemain;
    logic [robSize-1:0] wbDone;

    logic [dispatchWidth-1:0] ramWe;
    logic [dispatchWidth-1:0][robIdxWidth-1:0] ramWaddr;
    logic [dispatchWidth-1:0][entryWidth-1:0] ramWdata;
    logic [commitWidth-1:0][robIdxWidth-1:0] ramRaddr;
    logic [commitWidth-1:0][entryWidth-1:0] ramRdata;

    logic pipeIdle;
    logic [$clog2(dispatchWidth):0] dispNum;
    logic [$clog2(dispatchWidth):0] dispAccept;
    logic [commitWidth-1:0] headDone;
    logic [commitWidth-1:0] commitMask;
    logic [commitWidth-1:0] walkMask;
    logic [$clog2(commitWidth):0] commitNum;
    logic [$clog2(commitWidth):0] walkNum;

    logic [commitWidth-1:0] laneWe;
    logic [commitWidth-1:0][archRegWidth-1:0] laneVrd;
    logic [commitWidth-1:0][physRegWidth-1:0] lanePrd;

    logic [wbPorts-1:0][robIdxWidth-1:0] wbOffset;
    logic [wbPorts-1:0] wbLive;

    robDataRam dataRam (
        .clk   (clk),
        .we    (ramWe),
        .waddr (ramWaddr),
        .wdata (ramWdata),
        .raddr (ramRaddr),
        .rdata (ramRdata)
    );

    assign occupied = robSize - freeCount;

    // nothing enters or leaves while a redirect is pending or the walk is still visible.
    assign pipeIdle = !inWalk && !retire.walking && !redirectEn;

    always_comb begin
        dispNum = '0;
        for (int i = 0; i < dispatchWidth; i++) begin
            dispNum = dispNum + dispatch.en[i];
        end
    end

    assign dispatch.ready = pipeIdle && (freeCount >= dispNum);
    assign dispatch.robTag = tail;
    assign dispAccept = dispatch.ready ? dispNum : '0;

    always_comb begin
        for (int i = 0; i < dispatchWidth; i++) begin
            ramWe[i] = dispatch.en[i] && dispatch.ready;
            ramWaddr[i] = tail[robIdxWidth-1:0] + robIdxWidth'(i);
            ramWdata[i] = {dispatch.we[i], dispatch.vrd[i], dispatch.prd[i]};
        end
    end

    // idle reads the head pair, the walk reads back from just below the tail.
    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            if (inWalk) begin
                ramRaddr[i] = tail[robIdxWidth-1:0] - robIdxWidth'(i + 1);
            end else begin
                ramRaddr[i] = head[robIdxWidth-1:0] + robIdxWidth'(i);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < commitWidth; i++) begin
            headDone[i] = wbDone[ramRaddr[i]] && (occupied > i);
            walkMask[i] = inWalk && (walkRemain > i);
        end
        commitMask[0] = headDone[0] && pipeIdle;
        for (int i = 1; i < commitWidth; i++) begin
            commitMask[i] = headDone[i] && commitMask[i-1]; // stop at the first pending slot.
        end
    end

    always_comb begin
        commitNum = '0;
        walkNum = '0;
        for (int i = 0; i < commitWidth; i++) begin
            commitNum = commitNum + commitMask[i];
            walkNum = walkNum + walkMask[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            inWalk <= 1'b0;
            head <= '0;
            tail <= '0;
            freeCount <= robSize;
            walkRemain <= '0;
            wbDone <= '0;
            retire.commitEn <= '0;
            retire.walkEn <= '0;
            retire.walking <= 1'b0;
        end else begin
            retire.commitEn <= commitMask;
            retire.walkEn <= walkMask;
            retire.walking <= inWalk; // one cycle behind the state, so an empty walk still shows.
            for (int i = 0; i < commitWidth; i++) begin
                if (commitMask[i] || walkMask[i]) begin
                    wbDone[ramRaddr[i]] <= 1'b0;
                end
            end
            for (int p = 0; p < wbPorts; p++) begin
                if (wbEn[p]) begin
                    wbDone[wbIdx[p]] <= 1'b1;
                end
            end
            if (inWalk) begin
                tail <= tail - walkNum;
                freeCount <= freeCount + walkNum;
                walkRemain <= walkRemain - walkNum;
                if (walkRemain <= commitWidth) begin
                    inWalk <= 1'b0;
                end
            end else if (redirectEn) begin
                inWalk <= 1'b1;
                walkRemain <= tail - redirectTag - 1'b1; // slots younger than the redirect.
            end else begin
                head <= head + commitNum;
                tail <= tail + dispAccept;
                freeCount <= freeCount + commitNum - dispAccept;
            end
        end
    end

    // commit and walk lanes share one set of payload registers.
    always_ff @(posedge clk) begin
        for (int i = 0; i < commitWidth; i++) begin
            laneWe[i] <= ramRdata[i][entryWidth-1];
            laneVrd[i] <= ramRdata[i][physRegWidth +: archRegWidth];
            lanePrd[i] <= ramRdata[i][physRegWidth-1:0];
        end
    end

    assign retire.commitWe = laneWe;
    assign retire.commitVrd = laneVrd;
    assign retire.commitPrd = lanePrd;
    assign retire.walkWe = laneWe;
    assign retire.walkVrd = laneVrd;
    assign retire.walkPrd = lanePrd;

    always_comb begin
        for (int p = 0; p < wbPorts; p++) begin
            wbOffset[p] = wbIdx[p] - head[robIdxWidth-1:0];
            wbLive[p] = {1'b0, wbOffset[p]} < occupied;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) freeCount <= robSize)
        else $error("free count %0d exceeds the buffer size.", freeCount);

    for (genvar p = 0; p < wbPorts; p++) begin : gWbCheck
        // an execution unit must only finish an instruction that is still in flight.
        assert property (@(posedge clk) disable iff (!rstN) wbEn[p] |-> wbLive[p])
            else $error("writeback port %0d names free slot %0d.", p, wbIdx[p]);
    end

endmodule

// File: hw/robTop.sv
`timescale 1ns/10ps

module robTop
    import robPkg::*;
(
    input  logic clk,
    input  logic rstN,

    input  logic [dispatchWidth-1:0] dispatchEn,
    input  logic [dispatchWidth-1:0] dispatchWe,
    input  logic [dispatchWidth-1:0][archRegWidth-1:0] dispatchVrd,
    input  logic [dispatchWidth-1:0][physRegWidth-1:0] dispatchPrd,
    output logic dispatchReady,
    output logic [robIdxWidth:0] dispatchTag,

    input  logic [wbPorts-1:0] wbEn,
    input  logic [wbPorts-1:0][robIdxWidth-1:0] wbIdx,

    input  logic redirectEn,
    input  logic [robIdxWidth:0] redirectTag,

    output logic [commitWidth-1:0] commitEn,
    output logic [commitWidth-1:0] commitWe,
    output logic [commitWidth-1:0][archRegWidth-1:0] commitVrd,
    output logic [commitWidth-1:0][physRegWidth-1:0] commitPrd,

    output logic walking,
    output logic [commitWidth-1:0] walkEn,
    output logic [commitWidth-1:0] walkWe,
    output logic [commitWidth-1:0][archRegWidth-1:0] walkVrd,
    output logic [commitWidth-1:0][physRegWidth-1:0] walkPrd
);

    dispatchIf dispatchBus ();
    retireIf retireBus ();

    assign dispatchBus.en = dispatchEn;
    assign dispatchBus.we = dispatchWe;
    assign dispatchBus.vrd = dispatchVrd;
    assign dispatchBus.prd = dispatchPrd;
    assign dispatchReady = dispatchBus.ready;
    assign dispatchTag = dispatchBus.robTag;

    assign commitEn = retireBus.commitEn;
    assign commitWe = retireBus.commitWe;
    assign commitVrd = retireBus.commitVrd;
    assign commitPrd = retireBus.commitPrd;
    assign walking = retireBus.walking;
    assign walkEn = retireBus.walkEn;
    assign walkWe = retireBus.walkWe;
    assign walkVrd = retireBus.walkVrd;
    assign walkPrd = retireBus.walkPrd;

    reorderBuffer rob (
        .clk         (clk),
        .rstN        (rstN),
        .dispatch    (dispatchBus),
        .wbEn        (wbEn),
        .wbIdx       (wbIdx),
        .redirectEn  (redirectEn),
        .redirectTag (redirectTag),
        .retire      (retireBus)
    );

endmodule

// File: tests/robTb.sv
`timescale 1ns/10ps

module robTb
    import robPkg::*;
();

    typedef enum {kindDispatchOne, kindDispatchTwo, kindWriteBack, kindRedirect, kindDrain} kindT;
    typedef struct {
        string name;
        kindT kind;
        int arg; // groups, writebacks, or the offset of the redirect slot from the head.
    } stepT;
    typedef struct packed {
        logic [robIdxWidth:0] tag;
        logic [entryWidth-1:0] payload; // {we, vrd, prd}.
    } slotT;

    localparam int numSteps = 17;

    stepT steps [numSteps] = '{
        '{"dispFirst", kindDispatchTwo, 1}, '{"dispSingle", kindDispatchOne, 1},
        '{"dispPair", kindDispatchTwo, 1}, '{"wbScatter", kindWriteBack, 3},
        '{"wbRemain", kindWriteBack, 2}, '{"drainFirst", kindDrain, 0},
        '{"fillUp", kindDispatchTwo, 8}, '{"fullRefuse", kindDispatchOne, 1},
        '{"wbPartial", kindWriteBack, 5}, '{"drainFull", kindDrain, 0},
        '{"dispWrapped", kindDispatchTwo, 3}, '{"wbSome", kindWriteBack, 2},
        '{"redirMid", kindRedirect, 1}, '{"dispAfter", kindDispatchTwo, 1},
        '{"redirOldest", kindRedirect, 0}, '{"redirNewest", kindRedirect, -1},
        '{"drainEnd", kindDrain, 0}
    };

    logic clk;
    logic rstN;
    logic [dispatchWidth-1:0] dispatchEn;
    logic [dispatchWidth-1:0] dispatchWe;
    logic [dispatchWidth-1:0][archRegWidth-1:0] dispatchVrd;
    logic [dispatchWidth-1:0][physRegWidth-1:0] dispatchPrd;
    logic dispatchReady;
    logic [robIdxWidth:0] dispatchTag;
    logic [wbPorts-1:0] wbEn;
    logic [wbPorts-1:0][robIdxWidth-1:0] wbIdx;
    logic redirectEn;
    logic [robIdxWidth:0] redirectTag;
    logic [commitWidth-1:0] commitEn;
    logic [commitWidth-1:0] commitWe;
    logic [commitWidth-1:0][archRegWidth-1:0] commitVrd;
    logic [commitWidth-1:0][physRegWidth-1:0] commitPrd;
    logic walking;
    logic [commitWidth-1:0] walkEn;
    logic [commitWidth-1:0] walkWe;
    logic [commitWidth-1:0][archRegWidth-1:0] walkVrd;
    logic [commitWidth-1:0][physRegWidth-1:0] walkPrd;

    slotT model [$]; // occupied slots, oldest at the front.
    logic [robSize-1:0] doneMark; // written-back flag per slot index.
    logic [robIdxWidth:0] modelTail;
    int seqNo;
    string curName;
    event sampled;

    robTop uut (.*);

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    function automatic string mismatch(input string what, input int expV, input int actV);
        return $sformatf("MISMATCH %s %s: expected %0h, actual %0h", curName, what, expV, actV);
    endfunction

    function automatic logic [entryWidth-1:0] payloadFor(input int n);
        return {n % 3 != 0, archRegWidth'(n * 7), physRegWidth'(n * 11 + 3)};
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (numSteps * 40) @(posedge clk);
        failRun("the run hung, the watchdog expired before the last step finished.");
    end

    task automatic checkRetire();
        slotT exp;
        logic [entryWidth-1:0] actual;
        assert (commitEn != 2'b10 && walkEn != 2'b10)
            else failRun("a retire group skips lane 0.");
        assert (walking || walkEn == '0)
            else failRun("walk lanes are valid while walking is low.");
        assert (!walking || commitEn == '0) else failRun("slots committed during a walk.");
        for (int i = 0; i < commitWidth; i++) begin
            if (commitEn[i] || walkEn[i]) begin
                assert (model.size() > 0)
                    else failRun("a slot left the buffer while none is occupied.");
                // a walk goes newest first.
                exp = commitEn[i] ? model.pop_front() : model.pop_back();
                actual = commitEn[i] ? {commitWe[i], commitVrd[i], commitPrd[i]}
                                     : {walkWe[i], walkVrd[i], walkPrd[i]};
                assert (walkEn[i] || doneMark[exp.tag[robIdxWidth-1:0]])
                    else failRun($sformatf("slot %0h committed before its writeback.", exp.tag));
                assert (actual == exp.payload)
                    else failRun(mismatch($sformatf("lane %0d", i), exp.payload, actual));
            end
        end
    endtask

    always @(negedge clk) begin
        if (rstN) begin
            checkRetire();
        end
        -> sampled;
    end

    task automatic dispatchGroups(input int lanes, input int groups);
        logic [dispatchWidth-1:0] en;
        logic [dispatchWidth-1:0][entryWidth-1:0] pay;
        logic expReady;
        for (int g = 0; g < groups; g++) begin
            en = '0;
            pay = '0;
            for (int i = 0; i < lanes; i++) begin
                en[i] = 1'b1;
                pay[i] = payloadFor(seqNo + i);
            end
            @(posedge clk);
            dispatchEn <= en;
            for (int i = 0; i < dispatchWidth; i++) begin
                dispatchWe[i] <= pay[i][entryWidth-1];
                dispatchVrd[i] <= pay[i][physRegWidth +: archRegWidth];
                dispatchPrd[i] <= pay[i][physRegWidth-1:0];
            end
            @(sampled);
            expReady = (int'(robSize) - model.size()) >= lanes;
            assert (dispatchReady == expReady)
                else failRun(mismatch("ready", expReady, dispatchReady));
            if (expReady) begin
                assert (dispatchTag == modelTail)
                    else failRun(mismatch("tag", modelTail, dispatchTag));
                for (int i = 0; i < lanes; i++) begin
                    model.push_back('{modelTail + i, pay[i]});
                    doneMark[(modelTail + i) % robSize] = 1'b0;
                end
                modelTail = modelTail + lanes;
                seqNo = seqNo + lanes;
            end
        end
        @(posedge clk);
        dispatchEn <= '0;
    endtask

    task automatic writeBackSlots(input int count);
        logic [robIdxWidth:0] pend [$];
        logic [wbPorts-1:0] en;
        logic [wbPorts-1:0][robIdxWidth-1:0] idx;
        int pick;
        foreach (model[i]) begin
            if (!doneMark[model[i].tag[robIdxWidth-1:0]]) begin
                pend.push_back(model[i].tag);
            end
        end
        while (count > 0 && pend.size() > 0) begin
            en = '0;
            idx = '0;
            for (int p = 0; p < wbPorts; p++) begin
                if (count > 0 && pend.size() > 0) begin
                    pick = int'($urandom % pend.size()); // any pending slot may finish next.
                    en[p] = 1'b1;
                    idx[p] = pend[pick][robIdxWidth-1:0];
                    pend.delete(pick);
                    count--;
                end
            end
            @(posedge clk);
            wbEn <= en;
            wbIdx <= idx;
            @(sampled);
            for (int p = 0; p < wbPorts; p++) begin
                if (en[p]) begin
                    doneMark[idx[p]] = 1'b1;
                end
            end
        end
        @(posedge clk);
        wbEn <= '0;
    endtask

    task automatic redirectWalk(input int arg);
        int keep;
        logic [robIdxWidth:0] target;
        // let finished head slots retire first so the kept range is settled.
        while (model.size() > 0 && doneMark[model[0].tag[robIdxWidth-1:0]]) begin
            @(sampled);
        end
        assert (model.size() > 0) else failRun("a redirect step found the buffer empty.");
        keep = (arg < 0 || arg >= model.size()) ? model.size() : arg + 1;
        target = model[keep-1].tag;
        @(posedge clk);
        redirectEn <= 1'b1;
        redirectTag <= target;
        @(posedge clk);
        redirectEn <= 1'b0;
        do @(sampled); while (!walking);
        while (walking) begin
            assert (!dispatchReady) else failRun("dispatch is ready during a walk.");
            @(sampled);
        end
        assert (dispatchReady) else failRun("dispatch stays blocked after the walk.");
        assert (model.size() == keep) else failRun(mismatch("slots kept", keep, model.size()));
        modelTail = target + 1'b1;
    endtask

    initial begin
        void'($urandom(32'h4dcef6c9));
        rstN <= 1'b0;
        dispatchEn <= '0;
        dispatchWe <= '0;
        dispatchVrd <= '0;
        dispatchPrd <= '0;
        wbEn <= '0;
        wbIdx <= '0;
        redirectEn <= 1'b0;
        redirectTag <= '0;
        doneMark = '0;
        modelTail = '0;
        seqNo = 0;
        curName = "reset";
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(sampled);
        assert (dispatchReady && dispatchTag == '0 && commitEn == '0 && walkEn == '0 && !walking)
            else failRun("the buffer is not idle and empty after reset.");
        for (int s = 0; s < numSteps; s++) begin
            curName = steps[s].name;
            case (steps[s].kind)
                kindDispatchOne: dispatchGroups(1, steps[s].arg);
                kindDispatchTwo: dispatchGroups(2, steps[s].arg);
                kindWriteBack: writeBackSlots(steps[s].arg);
                kindRedirect: redirectWalk(steps[s].arg);
                default: begin
                    writeBackSlots(int'(robSize));
                    while (model.size() != 0) @(sampled);
                end
            endcase
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: vlog.f
common/robPkg.sv
common/robIf.sv
rob/robDataRam.sv
rob/reorderBuffer.sv
hw/robTop.sv
tests/robTb.sv

// File: Bender.yml
package:
  name: rob

sources:
  - common/robPkg.sv
  - common/robIf.sv
  - rob/robDataRam.sv
  - rob/reorderBuffer.sv
  - hw/robTop.sv
  - target: test
    files:
      - tests/robTb.sv
